//--- design/ntm_cosine_macros.svh
// Project wide widths for the cosine engine, included before anything that sizes words or sums
`ifndef NTM_COSINE_MACROS_SVH
`define NTM_COSINE_MACROS_SVH

// Data word and modulus width
`define NTM_DATA_SIZE 16

// Row count, row length and loop index width
`define NTM_INDEX_SIZE 8

`endif

//--- design/ntm_cosine_pkg.sv
// Shared types of the cosine engine, imported by every RTL module of the project
`default_nettype none

`include "ntm_cosine_macros.svh"

package ntm_cosine_pkg;

  ////////////////////
  // Data types
  ////////////////////

  // One residue or raw data word
  typedef logic [`NTM_DATA_SIZE-1:0] ntm_word_t;

  // Full product of two words, before reduction
  typedef logic [2*`NTM_DATA_SIZE-1:0] ntm_product_t;

  // Sizes and loop indices
  typedef logic [`NTM_INDEX_SIZE-1:0] ntm_index_t;

  ////////////////////
  // Control FSM
  ////////////////////

  typedef enum logic [1:0] {
    STATE_IDLE,
    STATE_INPUT,
    STATE_COMBINE
  } ntm_cosine_state_t;

endpackage

`default_nettype wire

//--- design/ntm_modular_accumulator.sv
// Running sum of products modulo M, one instance per row sum (dot product or a norm)
`timescale 1ns/1ps
`default_nettype none

`include "ntm_cosine_macros.svh"

module ntm_modular_accumulator
  import ntm_cosine_pkg::*;
(
  input  logic      CLK,
  input  logic      RST,
  input  logic      clear,
  input  logic      enable,
  input  ntm_word_t modulus,
  input  ntm_word_t operand_a,
  input  ntm_word_t operand_b,
  output ntm_word_t sum
);

  // Full product and its residue
  ntm_product_t product_full;
  ntm_word_t    product_mod;
  // One extra bit for the carry of the addition
  logic [`NTM_DATA_SIZE:0] sum_wide;
  ntm_word_t    sum_next;

  always_comb begin
    product_full = ntm_product_t'(operand_a) * ntm_product_t'(operand_b);
    product_mod  = ntm_word_t'(product_full % ntm_product_t'(modulus));
    sum_wide     = {1'b0, sum} + {1'b0, product_mod};
    // Both terms below M, so one subtraction is enough
    if (sum_wide >= {1'b0, modulus}) begin
      sum_next = ntm_word_t'(sum_wide - {1'b0, modulus});
    end else begin
      sum_next = sum_wide[`NTM_DATA_SIZE-1:0];
    end
  end

  // Clear wins over a pair in the same cycle
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      sum <= '0;
    end else if (clear) begin
      sum <= '0;
    end else if (enable) begin
      sum <= sum_next;
    end
  end

endmodule

`default_nettype wire

//--- design/ntm_modular_inverse.sv
// Extended Euclid inverse modulo M, one quotient step per cycle, used by the row combiner
`timescale 1ns/1ps
`default_nettype none

module ntm_modular_inverse
  import ntm_cosine_pkg::*;
(
  input  logic      CLK,
  input  logic      RST,
  input  logic      start,
  input  ntm_word_t modulus,
  input  ntm_word_t value,
  output logic      done,
  output ntm_word_t inverse,
  output logic      none
);

  logic         busy;
  logic         launch;
  logic         finish;
  // Remainder pair and Bezout coefficient pair
  ntm_word_t    r_prev;
  ntm_word_t    r_curr;
  ntm_word_t    t_prev;
  ntm_word_t    t_curr;
  // One step of the algorithm
  ntm_word_t    quotient;
  ntm_word_t    remainder;
  ntm_product_t q_t_full;
  ntm_word_t    q_t_mod;
  ntm_word_t    t_next;

  assign launch = start && !busy && (value != '0);
  // Remainder reached zero, gcd sits in r_prev
  assign finish = busy && (r_curr == '0);

  always_comb begin
    if (r_curr != '0) begin
      quotient  = r_prev / r_curr;
      remainder = r_prev % r_curr;
    end else begin
      quotient  = '0;
      remainder = r_prev;
    end
    // t_prev - q * t_curr kept in 0 .. M-1
    q_t_full = ntm_product_t'(quotient) * ntm_product_t'(t_curr);
    q_t_mod  = ntm_word_t'(q_t_full % ntm_product_t'(modulus));
    if (t_prev >= q_t_mod) begin
      t_next = t_prev - q_t_mod;
    end else begin
      t_next = t_prev - q_t_mod + modulus;
    end
  end

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      busy <= 1'b0;
      done <= 1'b0;
      none <= 1'b0;
    end else begin
      done <= 1'b0;
      if (start && !busy && (value == '0)) begin
        // Zero has no inverse, answer at once
        done <= 1'b1;
        none <= 1'b1;
      end else if (launch) begin
        busy <= 1'b1;
      end else if (finish) begin
        busy <= 1'b0;
        done <= 1'b1;
        // gcd other than one means no inverse
        none <= (r_prev != ntm_word_t'(1));
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (launch) begin
      r_prev <= modulus;
      r_curr <= value;
      t_prev <= '0;
      t_curr <= ntm_word_t'(1);
    end else if (busy && !finish) begin
      r_prev <= r_curr;
      r_curr <= remainder;
      t_prev <= t_curr;
      t_curr <= t_next;
    end
    if (finish) begin
      inverse <= t_prev;
    end else if (start && !busy) begin
      inverse <= '0;
    end
  end

endmodule

`default_nettype wire

//--- design/ntm_row_combiner.sv
// Squared cosine of one row from its three sums, dot^2 times the inverse of the norm product
`timescale 1ns/1ps
`default_nettype none

module ntm_row_combiner
  import ntm_cosine_pkg::*;
(
  input  logic      CLK,
  input  logic      RST,
  input  logic      start,
  input  ntm_word_t modulus,
  input  ntm_word_t dot_sum,
  input  ntm_word_t norm_a_sum,
  input  ntm_word_t norm_b_sum,
  output logic      result_valid,
  output ntm_word_t result
);

  // Inverse handshake
  logic         inv_start;
  logic         inv_done;
  logic         inv_none;
  ntm_word_t    inv_value;
  // Numerator and denominator residues
  ntm_product_t dot_full;
  ntm_product_t norm_full;
  ntm_word_t    dot_square;
  ntm_word_t    norm_product;
  // Scaling stage
  ntm_product_t scaled;
  logic         scaled_zero;
  logic         scaled_valid;

  always_comb begin
    dot_full  = ntm_product_t'(dot_sum) * ntm_product_t'(dot_sum);
    norm_full = ntm_product_t'(norm_a_sum) * ntm_product_t'(norm_b_sum);
  end

  // Strobes step along start, inverse, multiply, reduce
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      inv_start    <= 1'b0;
      scaled_valid <= 1'b0;
      result_valid <= 1'b0;
    end else begin
      inv_start    <= start;
      scaled_valid <= inv_done;
      result_valid <= scaled_valid;
    end
  end

  always_ff @(posedge CLK) begin
    if (start) begin
      dot_square   <= ntm_word_t'(dot_full % ntm_product_t'(modulus));
      norm_product <= ntm_word_t'(norm_full % ntm_product_t'(modulus));
    end
    if (inv_done) begin
      scaled      <= ntm_product_t'(dot_square) * ntm_product_t'(inv_value);
      scaled_zero <= inv_none;
    end
    // Zero norm product gives a zero row
    if (scaled_valid) begin
      result <= scaled_zero ? '0 : ntm_word_t'(scaled % ntm_product_t'(modulus));
    end
  end

  ntm_modular_inverse inverse_i (
    .CLK    (CLK),
    .RST    (RST),
    .start  (inv_start),
    .modulus(modulus),
    .value  (norm_product),
    .done   (inv_done),
    .inverse(inv_value),
    .none   (inv_none)
  );

endmodule

`default_nettype wire

//--- design/ntm_cosine_control.sv
// Job and row sequencer of the cosine engine, pairs A and B elements and drives the strobes
`timescale 1ns/1ps
`default_nettype none

module ntm_cosine_control
  import ntm_cosine_pkg::*;
(
  input  logic       CLK,
  input  logic       RST,
  input  logic       start,
  input  ntm_index_t size_i_in,
  input  ntm_index_t size_j_in,
  input  ntm_word_t  modulo_in,
  input  logic       data_a_in_enable,
  input  logic       data_b_in_enable,
  input  ntm_word_t  data_a_in,
  input  ntm_word_t  data_b_in,
  output logic       acc_clear,
  output logic       acc_enable,
  output ntm_word_t  pair_a,
  output ntm_word_t  pair_b,
  output ntm_word_t  modulus,
  output logic       combine_start,
  input  logic       result_valid,
  input  ntm_word_t  result,
  output logic       data_out_enable,
  output ntm_word_t  data_out,
  output logic       ready
);

  ////////////////////
  // Signals
  ////////////////////

  ntm_cosine_state_t state;
  // Job sizes and loop indices
  ntm_index_t size_i;
  ntm_index_t size_j;
  ntm_index_t index_i;
  ntm_index_t index_j;
  // Element waiting for its partner
  logic       a_pending;
  logic       b_pending;
  logic       have_a;
  logic       have_b;
  logic       in_input;
  logic       job_accept;
  logic       pair_issue;

  assign in_input   = (state == STATE_INPUT);
  assign job_accept = (state == STATE_IDLE) && start;
  assign have_a     = data_a_in_enable || a_pending;
  assign have_b     = data_b_in_enable || b_pending;
  assign pair_issue = in_input && have_a && have_b;

  ////////////////////
  // Job and pair data
  ////////////////////

  // pair_a and pair_b double as the holding registers
  always_ff @(posedge CLK) begin
    if (job_accept) begin
      size_i  <= size_i_in;
      size_j  <= size_j_in;
      modulus <= modulo_in;
    end
    if (in_input && data_a_in_enable) begin
      pair_a <= data_a_in;
    end
    if (in_input && data_b_in_enable) begin
      pair_b <= data_b_in;
    end
  end

  ////////////////////
  // FSM
  ////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state           <= STATE_IDLE;
      index_i         <= '0;
      index_j         <= '0;
      a_pending       <= 1'b0;
      b_pending       <= 1'b0;
      acc_clear       <= 1'b0;
      acc_enable      <= 1'b0;
      combine_start   <= 1'b0;
      data_out_enable <= 1'b0;
      data_out        <= '0;
      ready           <= 1'b0;
    end else begin
      // Single cycle strobes
      acc_clear       <= 1'b0;
      acc_enable      <= 1'b0;
      combine_start   <= 1'b0;
      data_out_enable <= 1'b0;
      ready           <= 1'b0;
      case (state)
        STATE_IDLE: begin
          if (start) begin
            index_i   <= '0;
            index_j   <= '0;
            a_pending <= 1'b0;
            b_pending <= 1'b0;
            acc_clear <= 1'b1;
            state     <= STATE_INPUT;
          end
        end
        STATE_INPUT: begin
          if (pair_issue) begin
            acc_enable <= 1'b1;
            a_pending  <= 1'b0;
            b_pending  <= 1'b0;
            // Last column closes the row
            if (index_j == size_j - ntm_index_t'(1)) begin
              index_j <= '0;
              state   <= STATE_COMBINE;
            end else begin
              index_j <= index_j + ntm_index_t'(1);
            end
          end else begin
            // A repeated element just overwrites the held one
            a_pending <= have_a;
            b_pending <= have_b;
          end
        end
        STATE_COMBINE: begin
          // Last pair lands in the sums this cycle
          combine_start <= acc_enable;
          if (result_valid) begin
            data_out        <= result;
            data_out_enable <= 1'b1;
            if (index_i == size_i - ntm_index_t'(1)) begin
              ready <= 1'b1;
              state <= STATE_IDLE;
            end else begin
              index_i   <= index_i + ntm_index_t'(1);
              acc_clear <= 1'b1;
              state     <= STATE_INPUT;
            end
          end
        end
        default: begin
          state <= STATE_IDLE;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

//--- design/ntm_matrix_cosine_similarity.sv
// Top of the row-wise squared cosine engine, control plus three accumulators and the combiner
`timescale 1ns/1ps
`default_nettype none

module ntm_matrix_cosine_similarity
  import ntm_cosine_pkg::*;
(
  input  logic       CLK,
  input  logic       RST,
  input  logic       start,
  input  ntm_index_t size_i_in,
  input  ntm_index_t size_j_in,
  input  ntm_word_t  modulo_in,
  input  logic       data_a_in_enable,
  input  logic       data_b_in_enable,
  input  ntm_word_t  data_a_in,
  input  ntm_word_t  data_b_in,
  output logic       data_out_enable,
  output ntm_word_t  data_out,
  output logic       ready
);

  // Control to accumulators
  logic      acc_clear;
  logic      acc_enable;
  ntm_word_t pair_a;
  ntm_word_t pair_b;
  ntm_word_t modulus;
  // Row sums
  ntm_word_t dot_sum;
  ntm_word_t norm_a_sum;
  ntm_word_t norm_b_sum;
  // Control to combiner
  logic      combine_start;
  logic      result_valid;
  ntm_word_t result;

  ntm_cosine_control control_i (
    .CLK             (CLK),
    .RST             (RST),
    .start           (start),
    .size_i_in       (size_i_in),
    .size_j_in       (size_j_in),
    .modulo_in       (modulo_in),
    .data_a_in_enable(data_a_in_enable),
    .data_b_in_enable(data_b_in_enable),
    .data_a_in       (data_a_in),
    .data_b_in       (data_b_in),
    .acc_clear       (acc_clear),
    .acc_enable      (acc_enable),
    .pair_a          (pair_a),
    .pair_b          (pair_b),
    .modulus         (modulus),
    .combine_start   (combine_start),
    .result_valid    (result_valid),
    .result          (result),
    .data_out_enable (data_out_enable),
    .data_out        (data_out),
    .ready           (ready)
  );

  // Dot product A.B
  ntm_modular_accumulator dot_accumulator_i (
    .CLK      (CLK),
    .RST      (RST),
    .clear    (acc_clear),
    .enable   (acc_enable),
    .modulus  (modulus),
    .operand_a(pair_a),
    .operand_b(pair_b),
    .sum      (dot_sum)
  );

  // Squared norm of A
  ntm_modular_accumulator norm_a_accumulator_i (
    .CLK      (CLK),
    .RST      (RST),
    .clear    (acc_clear),
    .enable   (acc_enable),
    .modulus  (modulus),
    .operand_a(pair_a),
    .operand_b(pair_a),
    .sum      (norm_a_sum)
  );

  // Squared norm of B
  ntm_modular_accumulator norm_b_accumulator_i (
    .CLK      (CLK),
    .RST      (RST),
    .clear    (acc_clear),
    .enable   (acc_enable),
    .modulus  (modulus),
    .operand_a(pair_b),
    .operand_b(pair_b),
    .sum      (norm_b_sum)
  );

  ntm_row_combiner combiner_i (
    .CLK         (CLK),
    .RST         (RST),
    .start       (combine_start),
    .modulus     (modulus),
    .dot_sum     (dot_sum),
    .norm_a_sum  (norm_a_sum),
    .norm_b_sum  (norm_b_sum),
    .result_valid(result_valid),
    .result      (result)
  );

endmodule

`default_nettype wire

//--- verification/ntm_cosine_tb.sv
// Testbench for the cosine engine that replays the jobs of the tests file with random strobe timing
`timescale 1ns/1ps
`default_nettype none

module ntm_cosine_tb
  import ntm_cosine_pkg::*;
();

  ////////////////////
  // DUT signals
  ////////////////////

  logic       CLK = 1'b0;
  logic       RST;
  logic       start;
  ntm_index_t size_i_in;
  ntm_index_t size_j_in;
  ntm_word_t  modulo_in;
  logic       data_a_in_enable;
  logic       data_b_in_enable;
  ntm_word_t  data_a_in;
  ntm_word_t  data_b_in;
  logic       data_out_enable;
  ntm_word_t  data_out;
  logic       ready;

  // Flat word image of the tests file
  ntm_word_t  test_words [0:255];
  integer     word_pos;
  integer     cycle_budget = 0;
  // Rows handed to the DUT and rows answered
  integer     rows_sent = 0;
  integer     rows_done = 0;
  ntm_word_t  expected_results [$];
  logic       expected_last [$];
  logic [31:0] lcg_state = 32'd81783;

  // 8 ns period
  always #4 CLK = ~CLK;

  ntm_matrix_cosine_similarity ntm_matrix_cosine_similarity_i (
    .CLK             (CLK),
    .RST             (RST),
    .start           (start),
    .size_i_in       (size_i_in),
    .size_j_in       (size_j_in),
    .modulo_in       (modulo_in),
    .data_a_in_enable(data_a_in_enable),
    .data_b_in_enable(data_b_in_enable),
    .data_a_in       (data_a_in),
    .data_b_in       (data_b_in),
    .data_out_enable (data_out_enable),
    .data_out        (data_out),
    .ready           (ready)
  );

  ////////////////////
  // Helpers
  ////////////////////

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("Checks failed");
    $fatal(1, "Stopped at the first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      abort_run($sformatf("FAILED %s: got 0x%0h, expected 0x%0h", name, actual, expected));
    end
  endtask

  // LCG step returning the upper bits
  function automatic logic [31:0] next_random();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return {17'd0, lcg_state[30:16]};
  endfunction

  // Room for strobes and gaps per pair, inverse and junk cycles per row
  function automatic integer test_cycle_budget();
    integer pos;
    integer cycles;
    pos = 0;
    cycles = 200;
    while (!$isunknown(test_words[pos]) && test_words[pos] != '0) begin
      cycles = cycles + 20 + test_words[pos+1] * (test_words[pos+2] * 12 + 120);
      pos = pos + 3 + test_words[pos+1] * (2 * test_words[pos+2] + 1);
    end
    return cycles;
  endfunction

  // One clock of stimulus 1 ns after the edge
  task automatic drive_cycle(input logic start_v, input logic en_a, input logic en_b,
                             input ntm_word_t a, input ntm_word_t b);
    @(posedge CLK);
    #1;
    start            = start_v;
    data_a_in_enable = en_a;
    data_b_in_enable = en_b;
    data_a_in        = a;
    data_b_in        = b;
  endtask

  task automatic wait_rows_done();
    while (rows_done < rows_sent) begin
      @(posedge CLK);
    end
  endtask

  // A first, B first or both together with a random gap
  task automatic send_pair(input ntm_word_t a, input ntm_word_t b);
    integer order;
    integer gap;
    order = next_random() % 3;
    gap   = next_random() % 3;
    if (order == 0) begin
      drive_cycle(1'b0, 1'b1, 1'b1, a, b);
    end else if (order == 1) begin
      drive_cycle(1'b0, 1'b1, 1'b0, a, '0);
      repeat (gap) drive_cycle(1'b0, 1'b0, 1'b0, '0, '0);
      drive_cycle(1'b0, 1'b0, 1'b1, '0, b);
    end else begin
      drive_cycle(1'b0, 1'b0, 1'b1, '0, b);
      repeat (gap) drive_cycle(1'b0, 1'b0, 1'b0, '0, '0);
      drive_cycle(1'b0, 1'b1, 1'b0, a, '0);
    end
    gap = next_random() % 2;
    repeat (gap) drive_cycle(1'b0, 1'b0, 1'b0, '0, '0);
  endtask

  task automatic run_job();
    ntm_index_t rows;
    ntm_index_t cols;
    integer     row;
    integer     col;
    rows      = ntm_index_t'(test_words[word_pos+1]);
    cols      = ntm_index_t'(test_words[word_pos+2]);
    size_i_in = rows;
    size_j_in = cols;
    modulo_in = test_words[word_pos];
    word_pos  = word_pos + 3;
    drive_cycle(1'b1, 1'b0, 1'b0, '0, '0);
    for (row = 0; row < rows; row++) begin
      wait_rows_done();
      expected_results.push_back(test_words[word_pos + 2 * cols]);
      expected_last.push_back(row == rows - 1);
      for (col = 0; col < cols; col++) begin
        send_pair(test_words[word_pos + 2 * col], test_words[word_pos + 2 * col + 1]);
      end
      word_pos  = word_pos + 2 * cols + 1;
      rows_sent = rows_sent + 1;
      // Restart and stray elements while the row result is computed
      size_i_in = 8'hff;
      modulo_in = 16'h0003;
      drive_cycle(1'b1, 1'b1, 1'b1, 16'hbeef, 16'h1234);
      drive_cycle(1'b0, 1'b1, 1'b1, 16'h5555, 16'haaaa);
      drive_cycle(1'b0, 1'b0, 1'b0, '0, '0);
    end
    wait_rows_done();
  endtask

  ////////////////////
  // Monitor
  ////////////////////

  // Outputs settle well before the falling edge
  always @(negedge CLK) begin
    if (RST === 1'b0) begin
      if (data_out_enable) begin
        if (expected_results.size() == 0) begin
          abort_run("data_out_enable pulsed while no row result was outstanding");
        end else begin
          check_value("data_out", data_out, expected_results.pop_front());
          check_value("ready", ready, expected_last.pop_front());
          rows_done = rows_done + 1;
        end
      end else begin
        check_value("ready", ready, 1'b0);
      end
    end
  end

  // Watchdog sized from the tests file
  initial begin
    wait (cycle_budget > 0);
    repeat (cycle_budget) @(posedge CLK);
    abort_run($sformatf("Timeout, the run did not end within %0d clock cycles", cycle_budget));
  end

  ////////////////////
  // Main sequence
  ////////////////////

  initial begin
    RST              = 1'b1;
    start            = 1'b0;
    size_i_in        = '0;
    size_j_in        = '0;
    modulo_in        = '0;
    data_a_in_enable = 1'b0;
    data_b_in_enable = 1'b0;
    data_a_in        = '0;
    data_b_in        = '0;
    word_pos         = 0;
    $readmemh("verification/ntm_cosine_tests.txt", test_words);
    if ($isunknown(test_words[0]) || test_words[0] == '0) begin
      abort_run("No test jobs found in verification/ntm_cosine_tests.txt");
    end
    cycle_budget = test_cycle_budget();
    repeat (4) @(posedge CLK);
    #1;
    // Reset values
    check_value("data_out_enable", data_out_enable, 1'b0);
    check_value("data_out", data_out, '0);
    check_value("ready", ready, 1'b0);
    RST = 1'b0;
    while (!$isunknown(test_words[word_pos]) && test_words[word_pos] != '0) begin
      run_job();
    end
    // Time for any extra row pulse to show up
    repeat (40) @(posedge CLK);
    $display("All checks passed");
    $finish;
  end

endmodule

`default_nettype wire

//--- verification/ntm_cosine_tests.txt
// Job line: modulus, row count, row length (hex); a zero modulus ends the file
// Row line: a0 b0 a1 b1 ... one pair per column, then the expected squared cosine (hex)
000d 03 03
0001 0004 0002 0005 0003 0006 0003
0000 0007 0000 0008 0000 0009 0000
0005 0003 000b 0001 0002 000a 000c
// Modulus 101, third row has an A norm of zero modulo M
0065 03 02
000a 001e 0014 0028 0055
0003 0006 0007 000e 0001
0001 0005 000a 0007 0000
// Largest 16 bit prime, operands near M
fff1 03 04
fff0 fff0 0001 0001 0001 0000 fff0 0000 7ff9
0001 0002 0002 0004 0003 0006 0004 0008 0001
0001 0002 0002 fff0 0003 0000 0004 0000 0000
// Single column rows
0007 02 01
0003 0005 0001
000e 0002 0000
// Smallest prime
0002 02 03
0001 0001 0001 0000 0001 0000 0001
0001 0001 0001 0001 0000 0001 0000
0000

//--- files.f
+incdir+design
design/ntm_cosine_pkg.sv
design/ntm_modular_accumulator.sv
design/ntm_modular_inverse.sv
design/ntm_row_combiner.sv
design/ntm_cosine_control.sv
design/ntm_matrix_cosine_similarity.sv
verification/ntm_cosine_tb.sv

//--- Bender.yml
package:
  name: ntm_cosine

sources:
  - include_dirs:
      - design
    files:
      - design/ntm_cosine_pkg.sv
      - design/ntm_modular_accumulator.sv
      - design/ntm_modular_inverse.sv
      - design/ntm_row_combiner.sv
      - design/ntm_cosine_control.sv
      - design/ntm_matrix_cosine_similarity.sv
  - target: test
    files:
      - verification/ntm_cosine_tb.sv
